/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_lanzones
FLIST     = flist.f
RUN_ARGS  = +verilator+error+limit+1000
OBJ_DIR   = obj_dir

SIM  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$($(SIM) $(RUN_ARGS))"; echo "$$out"; echo "$$out" | grep -qx 'NO ERRORS'

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
src/cpuPkg.sv
src/seqCtrl.sv
src/instDecode.sv
src/aluUnit.sv
src/regFile.sv
src/memPort.sv
src/lanzonesCore.sv
testbench/lanzones_sva.sv
testbench/tb_lanzones.sv

/* src/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit
   import cpuPkg::*;
#(
   parameter int DATA_W = XLEN
) (
   input  aluOpT             aluOp,
   input  logic              useImm,
   input  logic [DATA_W-1:0] srcA,
   input  logic [DATA_W-1:0] regB,
   input  logic [DATA_W-1:0] imm,
   output logic [DATA_W-1:0] aluOut
);

   logic [DATA_W-1:0] srcB;
   logic [4:0]        shamt;

   assign srcB  = useImm ? imm : regB;
   assign shamt = srcB[4:0];   // rv32 shift range

   always_comb begin
      case (aluOp)
         aluAdd:   aluOut = srcA + srcB;   // also load/store address
         aluSub:   aluOut = srcA - srcB;
         aluAnd:   aluOut = srcA & srcB;
         aluOr:    aluOut = srcA | srcB;
         aluXor:   aluOut = srcA ^ srcB;
         aluSlt:   aluOut = DATA_W'($signed(srcA) < $signed(srcB));
         aluSltu:  aluOut = DATA_W'(srcA < srcB);
         aluSll:   aluOut = srcA << shamt;
         aluSrl:   aluOut = srcA >> shamt;
         aluSra:   aluOut = $signed(srcA) >>> shamt;
         aluPassB: aluOut = srcB;
         default:  aluOut = '0;
      endcase
   end

endmodule

/* src/cpuPkg.sv */
package cpuPkg;

   parameter int XLEN       = 32;
   parameter int REG_ADDR_W = 5;

   // all-ones major opcode stops the core
   parameter logic [6:0] HALT_OPCODE = 7'h7F;

   typedef enum logic [6:0] {
      opImm   = 7'b0010011,
      opReg   = 7'b0110011,
      opLui   = 7'b0110111,
      opLoad  = 7'b0000011,
      opStore = 7'b0100011
   } opcodeT;

   typedef enum logic [3:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluOr,
      aluXor,
      aluSlt,
      aluSltu,
      aluSll,
      aluSrl,
      aluSra,
      aluPassB   // lui
   } aluOpT;

   typedef enum logic [2:0] {
      stHalted = 3'd0,
      stFetch  = 3'd1,
      stExec   = 3'd2,
      stMem    = 3'd3
   } seqStateT;

endpackage

/* src/instDecode.sv */
`timescale 1ns/1ps

module instDecode
   import cpuPkg::*;
#(
   parameter int DATA_W    = XLEN,
   parameter int REGS_LOG2 = REG_ADDR_W
) (
   input  logic [DATA_W-1:0]    instr,
   output logic [REGS_LOG2-1:0] rs1,
   output logic [REGS_LOG2-1:0] rs2,
   output logic [REGS_LOG2-1:0] rd,
   output logic [DATA_W-1:0]    imm,
   output aluOpT                aluOp,
   output logic                 useImm,
   output logic                 regWrite,
   output logic                 isLoad,
   output logic                 isStore,
   output logic                 invalid
);

   opcodeT             opcode;
   logic [2:0]         funct3;
   logic [6:0]         funct7;
   logic signed [31:0] immI;
   logic signed [31:0] immS;
   logic signed [31:0] immU;
   logic signed [31:0] immSel;

   assign opcode = opcodeT'(instr[6:0]);
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   assign rs1 = REGS_LOG2'(instr[19:15]);
   assign rs2 = REGS_LOG2'(instr[24:20]);
   assign rd  = REGS_LOG2'(instr[11:7]);

   assign immI = {{20{instr[31]}}, instr[31:20]};
   assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign immU = {instr[31:12], 12'b0};
   assign imm  = DATA_W'(immSel);   // sign extends past 32 bits

   always_comb begin
      aluOp    = aluAdd;
      useImm   = 1'b0;
      regWrite = 1'b0;
      isLoad   = 1'b0;
      isStore  = 1'b0;
      invalid  = 1'b0;
      immSel   = immI;
      case (opcode)
         opImm: begin
            useImm   = 1'b1;
            regWrite = 1'b1;
            case (funct3)
               3'b000:  aluOp = aluAdd;
               3'b010:  aluOp = aluSlt;
               3'b011:  aluOp = aluSltu;
               3'b100:  aluOp = aluXor;
               3'b110:  aluOp = aluOr;
               3'b111:  aluOp = aluAnd;
               3'b001:  aluOp = aluSll;
               default: aluOp = funct7[5] ? aluSra : aluSrl;
            endcase
            // shamt field shares bits with funct7
            if (funct3 == 3'b001 && funct7 != 7'b0000000) invalid = 1'b1;
            if (funct3 == 3'b101 && (funct7 & 7'b1011111) != 7'b0000000) invalid = 1'b1;
         end
         opReg: begin
            regWrite = 1'b1;
            case ({funct7, funct3})
               10'b0000000_000: aluOp = aluAdd;
               10'b0100000_000: aluOp = aluSub;
               10'b0000000_001: aluOp = aluSll;
               10'b0000000_010: aluOp = aluSlt;
               10'b0000000_011: aluOp = aluSltu;
               10'b0000000_100: aluOp = aluXor;
               10'b0000000_101: aluOp = aluSrl;
               10'b0100000_101: aluOp = aluSra;
               10'b0000000_110: aluOp = aluOr;
               10'b0000000_111: aluOp = aluAnd;
               default:         invalid = 1'b1;
            endcase
         end
         opLui: begin
            immSel   = immU;
            aluOp    = aluPassB;
            useImm   = 1'b1;
            regWrite = 1'b1;
         end
         opLoad: begin
            useImm   = 1'b1;
            isLoad   = (funct3 == 3'b010);   // word only
            regWrite = isLoad;
            invalid  = !isLoad;
         end
         opStore: begin
            immSel  = immS;
            useImm  = 1'b1;
            isStore = (funct3 == 3'b010);
            invalid = !isStore;
         end
         default: invalid = 1'b1;
      endcase
      if (invalid) regWrite = 1'b0;
   end

endmodule

/* src/lanzonesCore.sv */
`timescale 1ns/1ps

module lanzonesCore
   import cpuPkg::*;
#(
   parameter int DATA_W    = XLEN,
   parameter int REGS_LOG2 = REG_ADDR_W
) (
   input  logic              clk,
   input  logic              rstn,
   input  logic              RVld,
   input  logic [DATA_W-1:0] RData,
   input  logic              LEn,
   output logic              RRdy,
   output logic [DATA_W-1:0] RAddr,
   output logic              RWEn,
   output logic [DATA_W-1:0] RWData,
   output logic              Halt
);

   seqStateT             state;
   aluOpT                aluOp;
   logic [DATA_W-1:0]    pc, instr, imm, rdData1, rdData2, aluOut, wbData;
   logic [REGS_LOG2-1:0] rs1, rs2, rd;
   logic                 useImm, regWrite, isLoad, isStore, invalid, wbEn;

   seqCtrl #(.DATA_W(DATA_W)) uSeq (
      .clk, .rstn, .RVld, .LEn, .isLoad, .isStore, .invalid, .RData,
      .state, .pc, .instr, .Halt
   );

   instDecode #(.DATA_W(DATA_W), .REGS_LOG2(REGS_LOG2)) uDec (
      .instr, .rs1, .rs2, .rd, .imm, .aluOp, .useImm, .regWrite,
      .isLoad, .isStore, .invalid
   );

   regFile #(.DATA_W(DATA_W), .REGS_LOG2(REGS_LOG2)) uRegs (
      .clk, .rstn, .rs1, .rs2, .wrAddr(rd), .wrEn(wbEn), .wrData(wbData),
      .rdData1, .rdData2
   );

   aluUnit #(.DATA_W(DATA_W)) uAlu (
      .aluOp, .useImm, .srcA(rdData1), .regB(rdData2), .imm, .aluOut
   );

   memPort #(.DATA_W(DATA_W)) uMem (
      .clk, .rstn, .RVld, .RData, .state, .pc, .aluOut, .storeData(rdData2),
      .regWrite, .isLoad, .isStore, .RRdy, .RWEn, .RAddr, .RWData, .wbEn, .wbData
   );

endmodule

/* src/memPort.sv */
`timescale 1ns/1ps

module memPort
   import cpuPkg::*;
#(
   parameter int DATA_W = XLEN
) (
   input  logic              clk,
   input  logic              rstn,
   input  logic              RVld,
   input  logic [DATA_W-1:0] RData,
   input  seqStateT          state,
   input  logic [DATA_W-1:0] pc,
   input  logic [DATA_W-1:0] aluOut,
   input  logic [DATA_W-1:0] storeData,
   input  logic              regWrite,
   input  logic              isLoad,
   input  logic              isStore,
   output logic              RRdy,
   output logic              RWEn,
   output logic [DATA_W-1:0] RAddr,
   output logic [DATA_W-1:0] RWData,
   output logic              wbEn,
   output logic [DATA_W-1:0] wbData
);

   logic              loadPending;
   logic [DATA_W-1:0] loadData;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         RRdy        <= 1'b0;
         RWEn        <= 1'b0;
         loadPending <= 1'b0;
      end
      else begin
         loadPending <= (state == stMem) && RVld && isLoad;
         if (RVld) begin   // end of transaction
            RRdy <= 1'b0;
            RWEn <= 1'b0;
         end
         else if (state == stFetch || state == stMem) begin
            RRdy <= 1'b1;
            RWEn <= (state == stMem) && isStore;
         end
         else begin
            RRdy <= 1'b0;
            RWEn <= 1'b0;
         end
      end
   end

   // address and data frozen while RRdy is up
   always_ff @(posedge clk) begin
      if (!RRdy) begin
         RAddr  <= (state == stMem) ? aluOut : pc;
         RWData <= (state == stMem && isStore) ? storeData : '0;
      end
      if (state == stMem && RVld) begin
         loadData <= RData;
      end
   end

   assign wbEn   = loadPending || (state == stExec && regWrite && !isLoad);
   assign wbData = loadPending ? loadData : aluOut;

endmodule

/* src/regFile.sv */
`timescale 1ns/1ps

module regFile
   import cpuPkg::*;
#(
   parameter int DATA_W    = XLEN,
   parameter int REGS_LOG2 = REG_ADDR_W
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic [REGS_LOG2-1:0] rs1,
   input  logic [REGS_LOG2-1:0] rs2,
   input  logic [REGS_LOG2-1:0] wrAddr,
   input  logic                 wrEn,
   input  logic [DATA_W-1:0]    wrData,
   output logic [DATA_W-1:0]    rdData1,
   output logic [DATA_W-1:0]    rdData2
);

   logic [DATA_W-1:0] regs [2**REGS_LOG2];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < 2**REGS_LOG2; i++) begin
            regs[i] <= '0;
         end
      end
      else if (wrEn && wrAddr != '0) begin   // x0 is never written
         regs[wrAddr] <= wrData;
      end
   end

   assign rdData1 = (rs1 == '0) ? '0 : regs[rs1];
   assign rdData2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* src/seqCtrl.sv */
`timescale 1ns/1ps

module seqCtrl
   import cpuPkg::*;
#(
   parameter int DATA_W = XLEN
) (
   input  logic              clk,
   input  logic              rstn,
   input  logic              RVld,
   input  logic              LEn,
   input  logic              isLoad,
   input  logic              isStore,
   input  logic              invalid,
   input  logic [DATA_W-1:0] RData,
   output seqStateT          state,
   output logic [DATA_W-1:0] pc,
   output logic [DATA_W-1:0] instr,
   output logic              Halt
);

   logic stopInst;

   // halt opcode or anything the decoder rejects
   assign stopInst = (instr[6:0] == HALT_OPCODE) || invalid;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= stHalted;
         pc    <= '0;
         Halt  <= 1'b1;
      end
      else begin
         case (state)
            stHalted: begin
               if (LEn) begin   // resume from current pc
                  state <= stFetch;
                  Halt  <= 1'b0;
               end
            end
            stFetch: begin
               if (RVld) begin
                  state <= stExec;
                  pc    <= pc + 1'b1;   // word addressed
               end
            end
            stExec: begin
               if (stopInst) begin
                  state <= stHalted;
                  Halt  <= 1'b1;
               end
               else if (isLoad || isStore) begin
                  state <= stMem;
               end
               else begin
                  state <= stFetch;
               end
            end
            stMem: begin
               if (RVld) begin
                  state <= stFetch;
               end
            end
            default: begin
               state <= stHalted;
               Halt  <= 1'b1;
            end
         endcase
      end
   end

   // instruction word held until the next fetch returns
   always_ff @(posedge clk) begin
      if (state == stFetch && RVld) begin
         instr <= RData;
      end
   end

endmodule

/* testbench/lanzones_sva.sv */
`timescale 1ns/1ps

module lanzones_sva
   import cpuPkg::*;
#(
   parameter int DATA_W    = XLEN,
   parameter int REGS_LOG2 = REG_ADDR_W
) (
   input logic                 clk,
   input logic                 rstn,
   input logic                 RRdy,
   input logic                 RVld,
   input logic                 RWEn,
   input logic [DATA_W-1:0]    RAddr,
   input logic [DATA_W-1:0]    RWData,
   input logic                 Halt,
   input logic [REGS_LOG2-1:0] rs2
);

   int failCount = 0;

   resetIdle: assert property (@(posedge clk) $rose(rstn) |-> (Halt && !RRdy && !RWEn))
      else begin
         failCount++;
         $error("core is not halted and idle after reset");
      end

   haltQuiet: assert property (@(posedge clk) disable iff (!rstn)
      Halt |-> (!RRdy && !RWEn))
      else begin
         failCount++;
         $error("bus request raised while halted");
      end

   // request fields frozen until memory answers
   holdRequest: assert property (@(posedge clk) disable iff (!rstn)
      (RRdy && !RVld) |=> (RRdy && $stable(RAddr) && $stable(RWEn) && $stable(RWData)))
      else begin
         failCount++;
         $error("bus request changed before RVld");
      end

   dropAfterValid: assert property (@(posedge clk) disable iff (!rstn) RVld |=> !RRdy)
      else begin
         failCount++;
         $error("RRdy still high in the cycle after RVld");
      end

   zeroStore: assert property (@(posedge clk) disable iff (!rstn)
      (RRdy && RWEn && rs2 == '0) |-> (RWData == '0))   // sw of x0
      else begin
         failCount++;
         $error("store of register zero carries nonzero data");
      end

endmodule

bind lanzonesCore lanzones_sva #(.DATA_W(DATA_W), .REGS_LOG2(REGS_LOG2)) protocolChk (
   .clk(clk),
   .rstn(rstn),
   .RRdy(RRdy),
   .RVld(RVld),
   .RWEn(RWEn),
   .RAddr(RAddr),
   .RWData(RWData),
   .Halt(Halt),
   .rs2(rs2)
);

/* testbench/tb_lanzones.sv */
`timescale 1ns/1ps

module tb_lanzones;

   localparam int          MAX_DELAY = 3;
   localparam logic [31:0] DATA_BASE = 32'd128;   // fetches stay below this
   localparam logic [6:0]  OP_IMM    = 7'b0010011;
   localparam logic [6:0]  OP_LOAD   = 7'b0000011;
   // add sub and or xor slt sltu sll srl sra
   localparam logic [2:0]  OP_F3 [10] = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100,
                                          3'b010, 3'b011, 3'b001, 3'b101, 3'b101};
   localparam logic [6:0]  OP_F7 [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00,
                                          7'h00, 7'h00, 7'h00, 7'h00, 7'h20};

   logic        clk = 1'b0;
   logic        rstn = 1'b0;
   logic        RVld = 1'b0;
   logic [31:0] RData = '0;
   logic        LEn = 1'b0;
   logic        RRdy, RWEn, Halt;
   logic [31:0] RAddr, RWData;

   logic [31:0] mem [1024];
   logic [31:0] expData [1024];
   logic        expSet [1024];
   logic [31:0] haltPc [3];
   logic [31:0] opSeed = 32'd59;
   logic [31:0] delaySeed = 32'd59;
   logic [31:0] lastFetch = 32'hFFFF_FFFF;
   logic        busy = 1'b0;
   int          waitCnt = 0;
   int          progLen = 0;
   int          expStores = 0;
   int          storeCount = 0;
   int          mismatchCount = 0;
   int          otherErrors = 0;
   int          totalErrors = 0;
   int          cycles = 0;
   int          cycleLimit = 100000;

   lanzonesCore DUT (
      .clk, .rstn, .RVld, .RData, .LEn, .RRdy, .RAddr, .RWEn, .RWData, .Halt
   );

   always #50 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // expected result of each kept operation
   function automatic logic [31:0] modelOp(input int sel, input logic [31:0] a,
                                           input logic [31:0] b);
      case (sel)
         0:       return a + b;
         1:       return a - b;
         2:       return a & b;
         3:       return a | b;
         4:       return a ^ b;
         5:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         6:       return (a < b) ? 32'd1 : 32'd0;
         7:       return a << b[4:0];
         8:       return a >> b[4:0];
         default: return $signed(a) >>> b[4:0];
      endcase
   endfunction

   function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] encI(input logic [11:0] imm12, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
      return {imm12, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] encS(input logic [11:0] imm12, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
      return {imm12[11:5], rs2, rs1, 3'b010, imm12[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] encU(input logic [19:0] imm20, input logic [4:0] rd);
      return {imm20, rd, 7'b0110111};
   endfunction

   task automatic nextOperand(output logic [31:0] v);
      opSeed = xorshift(opSeed);
      v = opSeed;
   endtask

   task automatic emit(input logic [31:0] word);
      mem[progLen] = word;
      progLen++;
   endtask

   task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
      logic [31:0] hi;
      hi = value - {{20{value[11]}}, value[11:0]};   // addi sign extends
      emit(encU(hi[31:12], rd));
      emit(encI(value[11:0], rd, 3'b000, rd, OP_IMM));
   endtask

   task automatic expectStore(input logic [11:0] addr, input logic [31:0] value,
                              input logic [4:0] src);
      emit(encS(addr, src, 5'd0));
      expData[addr[9:0]] = value;
      expSet[addr[9:0]] = 1'b1;
      expStores++;
   endtask

   task automatic buildProgram();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] r;
      logic [11:0] imm12;
      for (int i = 0; i < 1024; i++) begin
         mem[i] = 32'hC0DE_0000 ^ 32'(i);
         expData[i] = '0;
         expSet[i] = 1'b0;
      end
      nextOperand(a);
      nextOperand(b);
      loadConst(5'd1, a);
      loadConst(5'd2, b);
      for (int k = 0; k < 10; k++) begin
         emit(encR(OP_F7[k], 5'd2, 5'd1, OP_F3[k], 5'd3));
         expectStore(12'h100 + 12'(k), modelOp(k, a, b), 5'd3);
      end
      for (int k = 0; k < 10; k++) begin
         if (k != 1) begin   // no subtract immediate
            nextOperand(r);
            imm12 = (k >= 7) ? {OP_F7[k], r[4:0]} : r[11:0];
            emit(encI(imm12, 5'd1, OP_F3[k], 5'd3, OP_IMM));
            expectStore(12'h110 + 12'(k), modelOp(k, a, {{20{imm12[11]}}, imm12}), 5'd3);
         end
      end
      nextOperand(r);
      emit(encU(r[31:12], 5'd3));
      expectStore(12'h120, {r[31:12], 12'h000}, 5'd3);
      nextOperand(r);
      mem[128] = r;   // data word for lw
      emit(encI(12'h080, 5'd0, 3'b010, 5'd4, OP_LOAD));
      expectStore(12'h121, r, 5'd4);
      emit(encI(12'h5A5, 5'd0, 3'b000, 5'd0, OP_IMM));
      expectStore(12'h122, 32'd0, 5'd0);
      haltPc[0] = 32'(progLen);
      emit(encI(12'h000, 5'd0, 3'b000, 5'd5, OP_LOAD));   // lb, now invalid
      expectStore(12'h123, a, 5'd1);
      haltPc[1] = 32'(progLen);
      emit(32'h0000_007F);
      expectStore(12'h124, b, 5'd2);
      haltPc[2] = 32'(progLen);
      emit(32'h0000_007F);
   endtask

   task automatic runUntilHalt();
      @(posedge clk);
      LEn <= 1'b1;
      @(posedge clk);
      LEn <= 1'b0;
      @(negedge clk);
      while (!Halt) begin
         @(negedge clk);
      end
   endtask

   // memory answers each request after 1 to 3 cycles
   always @(posedge clk) begin
      RVld <= 1'b0;
      if (!rstn) begin
         busy <= 1'b0;
      end
      else if (busy) begin
         if (waitCnt <= 1) begin
            busy <= 1'b0;
            RVld <= 1'b1;
            if (RWEn) begin
               storeCount <= storeCount + 1;
            end
            else begin
               RData <= mem[RAddr[9:0]];
            end
         end
         else begin
            waitCnt <= waitCnt - 1;
         end
      end
      else if (RRdy && !RVld) begin
         busy      <= 1'b1;
         waitCnt   <= 1 + int'(delaySeed % 3);
         delaySeed <= xorshift(delaySeed);
      end
      if (RRdy && RVld && !RWEn && RAddr < DATA_BASE) begin
         lastFetch <= RAddr;
      end
   end

   storeValue: assert property (@(posedge clk) disable iff (!rstn)
      (RRdy && RVld && RWEn) |-> (expSet[RAddr[9:0]] && RWData == expData[RAddr[9:0]]))
      else begin
         mismatchCount++;
         $display("Mismatch at %0t: RWData got %h expected %h (address %h)", $time,
                  $sampled(RWData), expData[$sampled(RAddr[9:0])], $sampled(RAddr));
      end

   fetchStep: assert property (@(posedge clk) disable iff (!rstn)
      (RRdy && RVld && !RWEn && RAddr < DATA_BASE) |-> (RAddr == lastFetch + 32'd1))
      else begin
         mismatchCount++;
         $display("Mismatch at %0t: RAddr got %h expected %h", $time,
                  $sampled(RAddr), $sampled(lastFetch) + 32'd1);
      end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > cycleLimit) begin
         $display("timeout: program did not finish within %0d cycles", cycleLimit);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   initial begin
      buildProgram();
      cycleLimit = 4 * progLen * 2 * (MAX_DELAY + 2);
      repeat (3) @(posedge clk);
      rstn <= 1'b1;
      repeat (4) @(posedge clk);   // idle while halted
      for (int h = 0; h < 3; h++) begin
         runUntilHalt();
         // core stops on the word it fetched last
         assert (lastFetch == haltPc[h])
            else begin
               mismatchCount++;
               $display("Mismatch at %0t: RAddr of halting fetch got %h expected %h",
                        $time, lastFetch, haltPc[h]);
            end
      end
      if (storeCount != expStores) begin
         otherErrors++;
         $display("wrong number of stores at %0t: saw %0d, expected %0d", $time,
                  storeCount, expStores);
      end
      totalErrors = mismatchCount + otherErrors + DUT.protocolChk.failCount;
      $display("errors: %0d mismatches, %0d protocol, %0d other", mismatchCount,
               DUT.protocolChk.failCount, otherErrors);
      if (totalErrors == 0) begin
         $display("NO ERRORS");
      end
      else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule
